//--- rtl/aes_const_pkg.sv
// AES-128 cipher constants.
// Round count, block geometry and the key schedule round constants.

`default_nettype none

package aes_const_pkg;

    // Ten rounds for a 128-bit key.
    localparam int NUM_ROUNDS = 10;

    // A block is a 4x4 byte state, column major as in FIPS-197.
    localparam int BYTES_PER_BLOCK = 16;
    localparam int WORDS_PER_BLOCK = 4;   // Also the key length in words.
    localparam int BYTES_PER_WORD = BYTES_PER_BLOCK / WORDS_PER_BLOCK;

    // Round constants for the key schedule.
    // Entry i serves round i+1 and lands in the first byte of the word.
    localparam logic [7:0] RCON [NUM_ROUNDS] = '{
        8'h01,
        8'h02,
        8'h04,
        8'h08,
        8'h10,
        8'h20,
        8'h40,
        8'h80,
        8'h1b,   // Reduced by the field polynomial from here on.
        8'h36
    };

endpackage

`default_nettype wire

//--- rtl/aes_types_pkg.sv
// AES data types.
// Bytes, words, blocks and the struct passed between pipeline stages.

`default_nettype none

package aes_types_pkg;

    import aes_const_pkg::*;

    typedef logic [7:0] aes_byte_t;

    // Byte 0 is the most significant, matching FIPS-197 ordering.
    typedef aes_byte_t [0:BYTES_PER_WORD-1] aes_word_t;
    typedef aes_byte_t [0:BYTES_PER_BLOCK-1] aes_block_t;

    // One pipeline slot.
    typedef struct packed {
        logic       valid;
        aes_block_t state;
        aes_block_t round_key;   // Key last added to state.
    } aes_stage_t;

endpackage

`default_nettype wire

//--- rtl/aes_sbox.sv
// AES forward S-box.
// Combinational byte substitution shared by SubBytes and SubWord.

`timescale 1ns/1ns
`default_nettype none

module aes_sbox import aes_types_pkg::*; (
    input  aes_byte_t in_byte,
    output aes_byte_t out_byte
);

    // One row per high nibble.
    localparam aes_byte_t [0:255] SBOX = {
        128'h637c777bf26b6fc53001672bfed7ab76,
        128'hca82c97dfa5947f0add4a2af9ca472c0,
        128'hb7fd9326363ff7cc34a5e5f171d83115,
        128'h04c723c31896059a071280e2eb27b275,
        128'h09832c1a1b6e5aa0523bd6b329e32f84,
        128'h53d100ed20fcb15b6acbbe394a4c58cf,
        128'hd0efaafb434d338545f9027f503c9fa8,
        128'h51a3408f929d38f5bcb6da2110fff3d2,
        128'hcd0c13ec5f974417c4a77e3d645d1973,
        128'h60814fdc222a908846eeb814de5e0bdb,
        128'he0323a0a4906245cc2d3ac629195e479,
        128'he7c8376d8dd54ea96c56f4ea657aae08,
        128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
        128'h703eb5664803f60e613557b986c11d9e,
        128'he1f8981169d98e949b1e87e9ce5528df,
        128'h8ca1890dbfe6426841992d0fb054bb16
    };

    assign out_byte = SBOX[in_byte];

endmodule

`default_nettype wire

//--- rtl/aes_key_step.sv
// AES-128 key schedule step.
// Derives the round key for ROUND_INDEX from the previous round key.

`timescale 1ns/1ns
`default_nettype none

module aes_key_step import aes_const_pkg::*, aes_types_pkg::*; #(
    parameter int ROUND_INDEX = 1
) (
    input  aes_block_t prev_key,
    output aes_block_t next_key
);

    aes_word_t rot_word;
    aes_byte_t sub_byte [BYTES_PER_WORD];

    // RotWord on the last key word.
    assign rot_word = {prev_key[BYTES_PER_BLOCK-3], prev_key[BYTES_PER_BLOCK-2],
                       prev_key[BYTES_PER_BLOCK-1], prev_key[BYTES_PER_BLOCK-4]};

    // SubWord.
    for (genvar b = 0; b < BYTES_PER_WORD; b++) begin : g_subword
        aes_sbox u_sbox (
            .in_byte  (rot_word[b]),
            .out_byte (sub_byte[b])
        );
    end

    // Each new word is the old word XOR the new word before it.
    always_comb begin
        aes_word_t carry;

        carry = {sub_byte[0] ^ RCON[ROUND_INDEX-1], sub_byte[1], sub_byte[2], sub_byte[3]};
        for (int w = 0; w < WORDS_PER_BLOCK; w++) begin
            carry = carry ^ prev_key[w*BYTES_PER_WORD +: BYTES_PER_WORD];
            next_key[w*BYTES_PER_WORD +: BYTES_PER_WORD] = carry;
        end
    end

endmodule

`default_nettype wire

//--- rtl/aes_round_stage.sv
// One registered AES round.
// SubBytes, ShiftRows, MixColumns (skipped in the last round), AddRoundKey.

`timescale 1ns/1ns
`default_nettype none

module aes_round_stage import aes_const_pkg::*, aes_types_pkg::*; #(
    parameter int ROUND_INDEX = 1
) (
    input  logic       clk,
    input  logic       rst,
    input  aes_stage_t stage_in,
    output aes_stage_t stage_out
);

    aes_byte_t  sub_byte [BYTES_PER_BLOCK];
    aes_block_t shifted_state;
    aes_block_t mixed_state;
    aes_block_t next_key;

    // Multiply by x in GF(2^8).
    function automatic aes_byte_t xtime(input aes_byte_t x);
        return {x[6:0], 1'b0} ^ (x[7] ? 8'h1b : 8'h00);
    endfunction

    // Fixed matrix 02 03 01 01, rotated per row.
    function automatic aes_word_t mix_column(input aes_word_t a);
        aes_word_t b;

        b[0] = xtime(a[0]) ^ xtime(a[1]) ^ a[1] ^ a[2] ^ a[3];
        b[1] = a[0] ^ xtime(a[1]) ^ xtime(a[2]) ^ a[2] ^ a[3];
        b[2] = a[0] ^ a[1] ^ xtime(a[2]) ^ xtime(a[3]) ^ a[3];
        b[3] = xtime(a[0]) ^ a[0] ^ a[1] ^ a[2] ^ xtime(a[3]);
        return b;
    endfunction

    // SubBytes.
    for (genvar i = 0; i < BYTES_PER_BLOCK; i++) begin : g_subbytes
        aes_sbox u_sbox (
            .in_byte  (stage_in.state[i]),
            .out_byte (sub_byte[i])
        );
    end

    // ShiftRows. Row r rotates left by r columns.
    always_comb begin
        for (int c = 0; c < WORDS_PER_BLOCK; c++) begin
            for (int r = 0; r < BYTES_PER_WORD; r++) begin
                shifted_state[c*BYTES_PER_WORD + r] =
                    sub_byte[((c + r) % WORDS_PER_BLOCK) * BYTES_PER_WORD + r];
            end
        end
    end

    if (ROUND_INDEX == NUM_ROUNDS) begin : g_final
        assign mixed_state = shifted_state;   // No MixColumns in the last round.
    end else begin : g_mix
        always_comb begin
            for (int c = 0; c < WORDS_PER_BLOCK; c++) begin
                mixed_state[c*BYTES_PER_WORD +: BYTES_PER_WORD] =
                    mix_column(shifted_state[c*BYTES_PER_WORD +: BYTES_PER_WORD]);
            end
        end
    end

    // Key for this round, expanded alongside the data.
    aes_key_step #(
        .ROUND_INDEX (ROUND_INDEX)
    ) u_key_step (
        .prev_key (stage_in.round_key),
        .next_key (next_key)
    );

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            stage_out <= '0;
        end else begin
            stage_out.valid     <= stage_in.valid;
            stage_out.state     <= mixed_state ^ next_key;   // AddRoundKey.
            stage_out.round_key <= next_key;
        end
    end

    // Pipeline slot comes out of reset empty.
    a_valid_after_reset: assert property (@(posedge clk) rst |=> !stage_out.valid);

    // Valid follows the upstream stage by one cycle.
    a_valid_follows: assert property (@(posedge clk) disable iff (rst)
        $past(!rst) |-> stage_out.valid == $past(stage_in.valid));

endmodule

`default_nettype wire

//--- rtl/aes_cipher.sv
// AES-128 encryption pipeline.
// Initial AddRoundKey register followed by ten round stages, one block per cycle.

`timescale 1ns/1ns
`default_nettype none

module aes_cipher import aes_const_pkg::*, aes_types_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       in_valid,
    input  aes_block_t plaintext,
    input  aes_block_t key,
    output logic       out_valid,
    output aes_block_t ciphertext
);

    aes_stage_t init_stage;
    aes_stage_t stage_chain [0:NUM_ROUNDS];

    // Round 0 is the key addition alone.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            init_stage <= '0;
        end else begin
            init_stage.valid     <= in_valid;
            init_stage.state     <= plaintext ^ key;
            init_stage.round_key <= key;
        end
    end

    assign stage_chain[0] = init_stage;

    for (genvar r = 1; r <= NUM_ROUNDS; r++) begin : g_round
        aes_round_stage #(
            .ROUND_INDEX (r)
        ) u_round (
            .clk       (clk),
            .rst       (rst),
            .stage_in  (stage_chain[r-1]),
            .stage_out (stage_chain[r])
        );
    end

    assign out_valid  = stage_chain[NUM_ROUNDS].valid;
    assign ciphertext = stage_chain[NUM_ROUNDS].state;

    // Fixed latency. Key register plus one register per round.
    a_latency: assert property (@(posedge clk) disable iff (rst)
        ##(NUM_ROUNDS + 1) 1'b1 |-> out_valid == $past(in_valid, NUM_ROUNDS + 1));

endmodule

`default_nettype wire

//--- tb/aes_ref_model.svh
// AES-128 software reference for the testbench.
// Own S-box table, xtime, key schedule and a block encrypt function.

`ifndef AES_REF_MODEL_SVH
`define AES_REF_MODEL_SVH

// Forward S-box, eight entries per line.
localparam logic [7:0] REF_SBOX [256] = '{
    8'h63, 8'h7c, 8'h77, 8'h7b, 8'hf2, 8'h6b, 8'h6f, 8'hc5,
    8'h30, 8'h01, 8'h67, 8'h2b, 8'hfe, 8'hd7, 8'hab, 8'h76,
    8'hca, 8'h82, 8'hc9, 8'h7d, 8'hfa, 8'h59, 8'h47, 8'hf0,
    8'had, 8'hd4, 8'ha2, 8'haf, 8'h9c, 8'ha4, 8'h72, 8'hc0,
    8'hb7, 8'hfd, 8'h93, 8'h26, 8'h36, 8'h3f, 8'hf7, 8'hcc,
    8'h34, 8'ha5, 8'he5, 8'hf1, 8'h71, 8'hd8, 8'h31, 8'h15,
    8'h04, 8'hc7, 8'h23, 8'hc3, 8'h18, 8'h96, 8'h05, 8'h9a,
    8'h07, 8'h12, 8'h80, 8'he2, 8'heb, 8'h27, 8'hb2, 8'h75,
    8'h09, 8'h83, 8'h2c, 8'h1a, 8'h1b, 8'h6e, 8'h5a, 8'ha0,
    8'h52, 8'h3b, 8'hd6, 8'hb3, 8'h29, 8'he3, 8'h2f, 8'h84,
    8'h53, 8'hd1, 8'h00, 8'hed, 8'h20, 8'hfc, 8'hb1, 8'h5b,
    8'h6a, 8'hcb, 8'hbe, 8'h39, 8'h4a, 8'h4c, 8'h58, 8'hcf,
    8'hd0, 8'hef, 8'haa, 8'hfb, 8'h43, 8'h4d, 8'h33, 8'h85,
    8'h45, 8'hf9, 8'h02, 8'h7f, 8'h50, 8'h3c, 8'h9f, 8'ha8,
    8'h51, 8'ha3, 8'h40, 8'h8f, 8'h92, 8'h9d, 8'h38, 8'hf5,
    8'hbc, 8'hb6, 8'hda, 8'h21, 8'h10, 8'hff, 8'hf3, 8'hd2,
    8'hcd, 8'h0c, 8'h13, 8'hec, 8'h5f, 8'h97, 8'h44, 8'h17,
    8'hc4, 8'ha7, 8'h7e, 8'h3d, 8'h64, 8'h5d, 8'h19, 8'h73,
    8'h60, 8'h81, 8'h4f, 8'hdc, 8'h22, 8'h2a, 8'h90, 8'h88,
    8'h46, 8'hee, 8'hb8, 8'h14, 8'hde, 8'h5e, 8'h0b, 8'hdb,
    8'he0, 8'h32, 8'h3a, 8'h0a, 8'h49, 8'h06, 8'h24, 8'h5c,
    8'hc2, 8'hd3, 8'hac, 8'h62, 8'h91, 8'h95, 8'he4, 8'h79,
    8'he7, 8'hc8, 8'h37, 8'h6d, 8'h8d, 8'hd5, 8'h4e, 8'ha9,
    8'h6c, 8'h56, 8'hf4, 8'hea, 8'h65, 8'h7a, 8'hae, 8'h08,
    8'hba, 8'h78, 8'h25, 8'h2e, 8'h1c, 8'ha6, 8'hb4, 8'hc6,
    8'he8, 8'hdd, 8'h74, 8'h1f, 8'h4b, 8'hbd, 8'h8b, 8'h8a,
    8'h70, 8'h3e, 8'hb5, 8'h66, 8'h48, 8'h03, 8'hf6, 8'h0e,
    8'h61, 8'h35, 8'h57, 8'hb9, 8'h86, 8'hc1, 8'h1d, 8'h9e,
    8'he1, 8'hf8, 8'h98, 8'h11, 8'h69, 8'hd9, 8'h8e, 8'h94,
    8'h9b, 8'h1e, 8'h87, 8'he9, 8'hce, 8'h55, 8'h28, 8'hdf,
    8'h8c, 8'ha1, 8'h89, 8'h0d, 8'hbf, 8'he6, 8'h42, 8'h68,
    8'h41, 8'h99, 8'h2d, 8'h0f, 8'hb0, 8'h54, 8'hbb, 8'h16
};

// Doubling in GF(2^8), reduced by x^8 + x^4 + x^3 + x + 1.
function automatic logic [7:0] ref_xtime(input logic [7:0] b);
    logic [7:0] shifted;

    shifted = b << 1;
    return shifted ^ (b[7] ? 8'h1b : 8'h00);
endfunction

function automatic logic [31:0] ref_sub_word(input logic [31:0] w);
    return {REF_SBOX[w[31:24]], REF_SBOX[w[23:16]], REF_SBOX[w[15:8]], REF_SBOX[w[7:0]]};
endfunction

// Next round key, words taken from the top of the vector down.
function automatic logic [127:0] ref_next_key(input logic [127:0] k, input logic [7:0] rcon);
    logic [31:0] w0;
    logic [31:0] w1;
    logic [31:0] w2;
    logic [31:0] w3;

    w0 = k[127:96] ^ ref_sub_word({k[23:0], k[31:24]}) ^ {rcon, 24'h000000};
    w1 = k[95:64] ^ w0;
    w2 = k[63:32] ^ w1;
    w3 = k[31:0] ^ w2;
    return {w0, w1, w2, w3};
endfunction

// Byte i of the state sits at row i%4, column i/4.
function automatic logic [127:0] ref_round(input logic [127:0] s, input logic [127:0] rk,
                                           input logic last);
    logic [127:0] t;
    logic [7:0]   a0;
    logic [7:0]   a1;
    logic [7:0]   a2;
    logic [7:0]   a3;

    for (int c = 0; c < 4; c++) begin
        for (int r = 0; r < 4; r++) begin
            t[127 - 8*(4*c + r) -: 8] = REF_SBOX[s[127 - 8*(4*((c + r) % 4) + r) -: 8]];
        end
    end
    if (!last) begin
        for (int c = 0; c < 4; c++) begin
            a0 = t[127 - 32*c -: 8];
            a1 = t[119 - 32*c -: 8];
            a2 = t[111 - 32*c -: 8];
            a3 = t[103 - 32*c -: 8];
            t[127 - 32*c -: 8] = ref_xtime(a0) ^ ref_xtime(a1) ^ a1 ^ a2 ^ a3;
            t[119 - 32*c -: 8] = a0 ^ ref_xtime(a1) ^ ref_xtime(a2) ^ a2 ^ a3;
            t[111 - 32*c -: 8] = a0 ^ a1 ^ ref_xtime(a2) ^ ref_xtime(a3) ^ a3;
            t[103 - 32*c -: 8] = ref_xtime(a0) ^ a0 ^ a1 ^ a2 ^ ref_xtime(a3);
        end
    end
    return t ^ rk;
endfunction

function automatic aes_block_t aes_encrypt_ref(input aes_block_t pt, input aes_block_t k);
    logic [127:0] s;
    logic [127:0] rk;
    logic [7:0]   rcon;

    rk   = k;
    s    = pt ^ k;
    rcon = 8'h01;   // Doubled each round.
    for (int r = 1; r <= NUM_ROUNDS; r++) begin
        rk   = ref_next_key(rk, rcon);
        s    = ref_round(s, rk, r == NUM_ROUNDS);
        rcon = ref_xtime(rcon);
    end
    return s;
endfunction

`endif

//--- tb/aes_cipher_tb.sv
// Testbench for the AES-128 pipeline.
// Checks every result against a software model and out_valid against the fixed latency.

`timescale 1ns/1ns
`default_nettype none

module aes_cipher_tb import aes_const_pkg::*, aes_types_pkg::*; ();

    localparam int LATENCY      = NUM_ROUNDS + 1;
    localparam int RESET_CYCLES = 4;
    localparam int STREAM_LEN   = 200;
    localparam int BUBBLE_LEN   = 150;
    localparam int DRAIN_LIMIT  = 4 * LATENCY;
    localparam int WATCHDOG_NS  = 200000;

    localparam logic [31:0] SEED = 32'ha91a06a9;

    // FIPS-197 Appendix C.1.
    localparam aes_block_t KAT_PT  = 128'h00112233445566778899aabbccddeeff;
    localparam aes_block_t KAT_KEY = 128'h000102030405060708090a0b0c0d0e0f;
    localparam aes_block_t KAT_CT  = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;

    logic       clk = 1'b0;
    logic       rst;
    logic       in_valid;
    aes_block_t plaintext;
    aes_block_t key;
    logic       out_valid;
    aes_block_t ciphertext;

    aes_block_t         exp_q [$];
    logic [LATENCY-1:0] valid_hist;
    int                 value_errors;
    int                 protocol_errors;
    int                 timeouts;
    int                 blocks_checked;

    `include "aes_ref_model.svh"

    aes_cipher DUT (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .plaintext  (plaintext),
        .key        (key),
        .out_valid  (out_valid),
        .ciphertext (ciphertext)
    );

    initial begin
        forever #10 clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Simulation did not finish within %0d ns", WATCHDOG_NS);
        $display("Result: FAILED");
        $finish;
    end

    task automatic check_block(input string name, input aes_block_t expected,
                               input aes_block_t actual);
        if (actual !== expected) begin
            value_errors++;
            $display("Fail at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic check_valid(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            value_errors++;
            $display("Fail at %0t ns: %s expected %b, got %b", $time, name, expected, actual);
        end
    endtask

    function automatic aes_block_t random_block();
        return {$urandom(), $urandom(), $urandom(), $urandom()};
    endfunction

    task automatic drive_block(input aes_block_t pt, input aes_block_t k);
        @(posedge clk);
        in_valid  <= 1'b1;
        plaintext <= pt;
        key       <= k;
    endtask

    task automatic idle_cycles(input int count);
        repeat (count) begin
            @(posedge clk);
            in_valid <= 1'b0;
        end
    endtask

    // Idles the inputs until every expected result has come out.
    task automatic drain_pipeline(input int limit);
        int cycles;

        cycles = 0;
        do begin
            @(posedge clk);
            in_valid <= 1'b0;
            cycles++;
        end while (exp_q.size() != 0 && cycles < limit);
        if (exp_q.size() != 0) begin
            timeouts++;
            $display("Timed out after %0d cycles waiting for the pipeline to drain", cycles);
        end
    endtask

    // Counts falling edges until out_valid is seen high.
    task automatic wait_out_valid(input int limit, output int cycles);
        logic found;

        found  = 1'b0;
        cycles = 0;
        while (!found && cycles < limit) begin
            @(negedge clk);
            if (out_valid) begin
                found = 1'b1;
            end else begin
                cycles++;
            end
        end
        if (!found) begin
            timeouts++;
            $display("Timed out after %0d cycles waiting for out_valid", limit);
        end
    endtask

    task automatic drive_stream(input int count);
        for (int i = 0; i < count; i++) begin
            drive_block(random_block(), random_block());
        end
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    task automatic check_stream_run(input int count);
        int cycles;

        wait_out_valid(DRAIN_LIMIT, cycles);
        for (int i = 1; i < count; i++) begin
            @(negedge clk);
            check_valid("out_valid in stream", 1'b1, out_valid);
        end
        @(negedge clk);
        check_valid("out_valid after stream", 1'b0, out_valid);
    endtask

    // Scoreboard. Samples on the falling edge, away from input changes.
    always @(negedge clk) begin
        if (rst) begin
            valid_hist = '0;
            exp_q.delete();   // In-flight blocks are lost.
            check_valid("out_valid", 1'b0, out_valid);
        end else begin
            check_valid("out_valid", valid_hist[LATENCY-1], out_valid);
            if (out_valid) begin
                if (exp_q.size() == 0) begin
                    protocol_errors++;
                    $display("Error at %0t ns: out_valid high with no result expected", $time);
                end else begin
                    check_block("ciphertext", exp_q.pop_front(), ciphertext);
                    blocks_checked++;
                end
            end
            valid_hist = {valid_hist[LATENCY-2:0], in_valid};
            if (in_valid) begin
                exp_q.push_back(aes_encrypt_ref(plaintext, key));
            end
        end
    end

    initial begin
        aes_block_t pt;
        int         latency;

        rst             = 1'b1;
        in_valid        = 1'b0;
        plaintext       = '0;
        key             = '0;
        valid_hist      = '0;
        value_errors    = 0;
        protocol_errors = 0;
        timeouts        = 0;
        blocks_checked  = 0;
        void'($urandom(SEED));

        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;

        // Known answer for the model and the DUT.
        check_block("reference model", KAT_CT, aes_encrypt_ref(KAT_PT, KAT_KEY));
        drive_block(KAT_PT, KAT_KEY);
        drain_pipeline(DRAIN_LIMIT);

        // Back-to-back stream.
        fork
            drive_stream(STREAM_LEN);
            check_stream_run(STREAM_LEN);
        join
        drain_pipeline(DRAIN_LIMIT);

        // Random bubbles.
        for (int i = 0; i < BUBBLE_LEN; i++) begin
            @(posedge clk);
            in_valid  <= ($urandom() % 3) != 0;
            plaintext <= random_block();
            key       <= random_block();
        end
        drain_pipeline(DRAIN_LIMIT);

        // Reset with blocks in flight.
        for (int i = 0; i < 6; i++) begin
            drive_block(random_block(), random_block());
        end
        @(posedge clk);
        rst      <= 1'b1;
        in_valid <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < 5; i++) begin
            @(negedge clk);
            check_valid("out_valid after reset", 1'b0, out_valid);
        end
        drive_block(random_block(), random_block());
        fork
            idle_cycles(LATENCY + 4);
            wait_out_valid(2 * LATENCY, latency);
        join
        if (latency != LATENCY) begin
            value_errors++;
            $display("Fail at %0t ns: latency expected %0d, got %0d", $time, LATENCY, latency);
        end
        drain_pipeline(DRAIN_LIMIT);

        // Edge keys and plaintexts.
        drive_block('0, '0);
        drive_block('1, '1);
        drive_block('0, '1);
        drive_block('1, '0);
        pt = random_block();
        for (int i = 0; i < 4; i++) begin
            drive_block(pt, random_block());
        end
        drive_block(pt, pt);
        drain_pipeline(DRAIN_LIMIT);
        idle_cycles(4);

        if (exp_q.size() != 0) begin
            protocol_errors++;
            $display("%0d expected results were never produced", exp_q.size());
        end
        $display("Summary: %0d blocks checked, %0d value errors, %0d protocol errors, %0d timeouts",
                 blocks_checked, value_errors, protocol_errors, timeouts);
        if (value_errors + protocol_errors + timeouts == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
+incdir+tb
rtl/aes_const_pkg.sv
rtl/aes_types_pkg.sv
rtl/aes_sbox.sv
rtl/aes_key_step.sv
rtl/aes_round_stage.sv
rtl/aes_cipher.sv
tb/aes_cipher_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the AES pipeline testbench with Verilator, runs it and checks the log.
set -e
set -o pipefail

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG=sim.log

rm -rf "$BUILD_DIR"
verilator --binary --timing --assert \
    -f compile.f \
    --top-module aes_cipher_tb \
    -Mdir "$BUILD_DIR" \
    -o aes_cipher_sim

"./$BUILD_DIR/aes_cipher_sim" | tee "$LOG"

if grep -q "Result: FAILED" "$LOG"; then
    echo "Simulation reported a failure."
    exit 1
fi
if ! grep -q "Result: PASSED" "$LOG"; then
    echo "Simulation ended without a result."
    exit 1
fi
echo "Simulation passed."
